// ==== rf_pkg.sv ====
package rf_pkg;

	// Geometry of the register file, fixed so the port structs have known widths
	localparam int rf_addr_width = 5;
	localparam int rf_data_width = 32;
	localparam int rf_num_byte = rf_data_width / 8;

	// Number of words addressed by a full index
	localparam int rf_num_words = 2 ** rf_addr_width;

	// One read port request, the address is sampled on en
	typedef struct packed {
		logic en;
		logic [rf_addr_width-1:0] addr;
	} rf_read_req_t;

	// One write port request, be selects the byte lanes of data to store
	typedef struct packed {
		logic en;
		logic [rf_addr_width-1:0] addr;
		logic [rf_data_width-1:0] data;
		logic [rf_num_byte-1:0] be;
	} rf_write_req_t;

	// Handy constant for an idle write port
	localparam rf_write_req_t rf_write_idle = '{
		en: 1'b0,
		addr: '0,
		data: '0,
		be: '0
	};

endpackage

// ==== core_pkg.sv ====
package core_pkg;

	// Operations of the three operand unit
	typedef enum logic [1:0] {
		op_madd = 2'd0,
		op_add3 = 2'd1,
		op_bsel = 2'd2,
		op_max3 = 2'd3
	} core_opcode_e;

	// Instruction strobe as it enters the core
	typedef struct packed {
		logic valid;
		core_opcode_e opcode;
		logic [rf_pkg::rf_addr_width-1:0] rs_a;
		logic [rf_pkg::rf_addr_width-1:0] rs_b;
		logic [rf_pkg::rf_addr_width-1:0] rs_c;
		logic [rf_pkg::rf_addr_width-1:0] rd;
		logic [rf_pkg::rf_num_byte-1:0] mask;
	} core_instr_t;

	// What travels beside the register file read latency
	typedef struct packed {
		logic valid;
		core_opcode_e opcode;
		logic [rf_pkg::rf_addr_width-1:0] rd;
		logic [rf_pkg::rf_num_byte-1:0] mask;
	} core_stage1_t;

	// Computed result on its way to writeback
	typedef struct packed {
		logic valid;
		logic [rf_pkg::rf_addr_width-1:0] rd;
		logic [rf_pkg::rf_num_byte-1:0] mask;
		logic [rf_pkg::rf_data_width-1:0] result;
	} core_stage2_t;

endpackage

// ==== operand_decoder.sv ====
`timescale 1ns/10ps

module operand_decoder (
	input logic clk,
	input logic rst_n,
	input core_pkg::core_instr_t instr,
	output rf_pkg::rf_read_req_t rd_req_a,
	output rf_pkg::rf_read_req_t rd_req_b,
	output rf_pkg::rf_read_req_t rd_req_c,
	output core_pkg::core_stage1_t stage1
);
	import core_pkg::*;

	core_stage1_t stage1_d;
	core_stage1_t stage1_q;

	// All three operands are fetched in the issue cycle
	always_comb begin
		rd_req_a.en = instr.valid;
		rd_req_a.addr = instr.rs_a;
		rd_req_b.en = instr.valid;
		rd_req_b.addr = instr.rs_b;
		rd_req_c.en = instr.valid;
		rd_req_c.addr = instr.rs_c;
	end

	// The record that has to wait one cycle for the read data
	always_comb begin
		stage1_d.valid = instr.valid;
		stage1_d.opcode = instr.opcode;
		stage1_d.rd = instr.rd;
		stage1_d.mask = instr.mask;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage1_q.valid <= 1'b0;
			stage1_q.opcode <= op_madd;
			stage1_q.rd <= '0;
			stage1_q.mask <= '0;
		end else begin
			stage1_q.valid <= stage1_d.valid;
			// Payload only moves with a real instruction
			if (stage1_d.valid) begin
				stage1_q.opcode <= stage1_d.opcode;
				stage1_q.rd <= stage1_d.rd;
				stage1_q.mask <= stage1_d.mask;
			end
		end
	end

	assign stage1 = stage1_q;

endmodule

// ==== register_file_3r_2w_be.sv ====
`timescale 1ns/10ps

module register_file_3r_2w_be #(
	parameter int ADDR_WIDTH = rf_pkg::rf_addr_width,
	parameter int DATA_WIDTH = rf_pkg::rf_data_width
) (
	input logic clk,
	input logic rst_n,
	input rf_pkg::rf_read_req_t rd_req_a,
	input rf_pkg::rf_read_req_t rd_req_b,
	input rf_pkg::rf_read_req_t rd_req_c,
	output logic [DATA_WIDTH-1:0] rd_data_a,
	output logic [DATA_WIDTH-1:0] rd_data_b,
	output logic [DATA_WIDTH-1:0] rd_data_c,
	input rf_pkg::rf_write_req_t wr_req_a,
	input rf_pkg::rf_write_req_t wr_req_b
);
	localparam int NUM_WORDS = 2 ** ADDR_WIDTH;
	localparam int NUM_BYTE = DATA_WIDTH / 8;

	// Storage is kept as byte lanes so each lane has its own write enable
	logic [NUM_WORDS-1:0][NUM_BYTE-1:0][7:0] mem;

	logic [ADDR_WIDTH-1:0] raddr_a;
	logic [ADDR_WIDTH-1:0] raddr_b;
	logic [ADDR_WIDTH-1:0] raddr_c;

	// Per byte lane decoded enables of both write ports
	logic [NUM_WORDS-1:0][NUM_BYTE-1:0] wen_a;
	logic [NUM_WORDS-1:0][NUM_BYTE-1:0] wen_b;

	// Write data split into lanes
	logic [NUM_BYTE-1:0][7:0] wdata_a;
	logic [NUM_BYTE-1:0][7:0] wdata_b;

	// Read addresses hold their last value while the enable is low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raddr_a <= '0;
			raddr_b <= '0;
			raddr_c <= '0;
		end else begin
			if (rd_req_a.en) begin
				raddr_a <= rd_req_a.addr;
			end
			if (rd_req_b.en) begin
				raddr_b <= rd_req_b.addr;
			end
			if (rd_req_c.en) begin
				raddr_c <= rd_req_c.addr;
			end
		end
	end

	// Data comes straight from the flops, so it already shows last cycle's writes
	assign rd_data_a = mem[raddr_a];
	assign rd_data_b = mem[raddr_b];
	assign rd_data_c = mem[raddr_c];

	assign wdata_a = wr_req_a.data;
	assign wdata_b = wr_req_b.data;

	always_comb begin
		for (int w = 0; w < NUM_WORDS; w++) begin
			for (int b = 0; b < NUM_BYTE; b++) begin
				wen_a[w][b] = wr_req_a.en && wr_req_a.be[b] &&
					(wr_req_a.addr == ADDR_WIDTH'(w));
				wen_b[w][b] = wr_req_b.en && wr_req_b.be[b] &&
					(wr_req_b.addr == ADDR_WIDTH'(w));
			end
		end
	end

	// Port B is the load port and wins a lane that both ports hit
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WORDS; w++) begin
			for (int b = 0; b < NUM_BYTE; b++) begin
				if (wen_b[w][b]) begin
					mem[w][b] <= wdata_b[b];
				end else if (wen_a[w][b]) begin
					mem[w][b] <= wdata_a[b];
				end
			end
		end
	end

endmodule

// ==== ternary_alu.sv ====
`timescale 1ns/10ps

module ternary_alu (
	input logic clk,
	input logic rst_n,
	input core_pkg::core_stage1_t stage1,
	input logic [rf_pkg::rf_data_width-1:0] op_a,
	input logic [rf_pkg::rf_data_width-1:0] op_b,
	input logic [rf_pkg::rf_data_width-1:0] op_c,
	output core_pkg::core_stage2_t stage2
);
	import rf_pkg::*;
	import core_pkg::*;

	logic [rf_data_width-1:0] product;
	logic [rf_data_width-1:0] max_ab;
	logic [rf_data_width-1:0] result;
	core_stage2_t stage2_q;

	// Only the low word of the product is kept
	assign product = op_a * op_b;
	assign max_ab = (op_a > op_b) ? op_a : op_b;

	always_comb begin
		case (stage1.opcode)
			op_madd: begin
				result = product + op_c;
			end
			op_add3: begin
				result = op_a + op_b + op_c;
			end
			op_bsel: begin
				// c works as the select mask, a where it is set
				result = (op_a & op_c) | (op_b & ~op_c);
			end
			op_max3: begin
				result = (max_ab > op_c) ? max_ab : op_c;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage2_q.valid <= 1'b0;
			stage2_q.rd <= '0;
			stage2_q.mask <= '0;
			stage2_q.result <= '0;
		end else begin
			stage2_q.valid <= stage1.valid;
			if (stage1.valid) begin
				stage2_q.rd <= stage1.rd;
				stage2_q.mask <= stage1.mask;
				stage2_q.result <= result;
			end
		end
	end

	assign stage2 = stage2_q;

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage (
	input core_pkg::core_stage2_t stage2,
	output rf_pkg::rf_write_req_t wr_req,
	output logic result_valid,
	output logic [rf_pkg::rf_addr_width-1:0] result_rd,
	output logic [rf_pkg::rf_data_width-1:0] result_data
);
	import rf_pkg::*;

	logic any_byte;
	logic do_write;

	// An empty mask still reports a result but leaves the register alone
	assign any_byte = |stage2.mask;
	assign do_write = stage2.valid && any_byte;

	always_comb begin
		wr_req = rf_write_idle;
		wr_req.en = do_write;
		wr_req.addr = stage2.rd;
		wr_req.data = stage2.result;
		wr_req.be = stage2.mask;
	end

	// Outside view is the full word regardless of the byte mask
	assign result_valid = stage2.valid;
	assign result_rd = stage2.rd;
	assign result_data = stage2.result;

endmodule

// ==== arith_core_top.sv ====
`timescale 1ns/10ps

module arith_core_top (
	input logic clk,
	input logic rst_n,
	input core_pkg::core_instr_t instr,
	input rf_pkg::rf_write_req_t load,
	output logic result_valid,
	output logic [rf_pkg::rf_addr_width-1:0] result_rd,
	output logic [rf_pkg::rf_data_width-1:0] result_data
);
	import rf_pkg::*;
	import core_pkg::*;

	rf_read_req_t rd_req_a;
	rf_read_req_t rd_req_b;
	rf_read_req_t rd_req_c;
	logic [rf_data_width-1:0] rd_data_a;
	logic [rf_data_width-1:0] rd_data_b;
	logic [rf_data_width-1:0] rd_data_c;
	core_stage1_t stage1;
	core_stage2_t stage2;
	rf_write_req_t wb_req;

	operand_decoder u_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.rd_req_a(rd_req_a),
		.rd_req_b(rd_req_b),
		.rd_req_c(rd_req_c),
		.stage1(stage1)
	);

	// Write port A is the core's writeback, port B the external load
	register_file_3r_2w_be #(
		.ADDR_WIDTH(rf_addr_width),
		.DATA_WIDTH(rf_data_width)
	) u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.rd_req_a(rd_req_a),
		.rd_req_b(rd_req_b),
		.rd_req_c(rd_req_c),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.rd_data_c(rd_data_c),
		.wr_req_a(wb_req),
		.wr_req_b(load)
	);

	ternary_alu u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.stage1(stage1),
		.op_a(rd_data_a),
		.op_b(rd_data_b),
		.op_c(rd_data_c),
		.stage2(stage2)
	);

	writeback_stage u_writeback (
		.stage2(stage2),
		.wr_req(wb_req),
		.result_valid(result_valid),
		.result_rd(result_rd),
		.result_data(result_data)
	);

endmodule

// ==== tb_arith_core.sv ====
`timescale 1ns/10ps

module tb_arith_core;
	import rf_pkg::*;
	import core_pkg::*;

	localparam int clk_period = 4;
	localparam int reset_cycles = 8;
	// Cycles driven by all test sections together including the drain
	localparam int test_cycles = 266;
	localparam int margin_cycles = 64;
	localparam core_instr_t no_instr = '0;

	logic clk;
	logic rst_n;
	core_instr_t instr;
	rf_write_req_t load;
	logic result_valid;
	logic [rf_addr_width-1:0] result_rd;
	logic [rf_data_width-1:0] result_data;

	// Reference register model and the writebacks still on their way to it
	logic [rf_data_width-1:0] model_regs [rf_num_words];
	core_stage2_t wb_pipe [2];
	logic [31:0] rng_state;
	int cycle_no;
	int check_count;
	int error_count;

	int exp_cycle [$];
	logic [rf_addr_width-1:0] exp_rd [$];
	logic [rf_data_width-1:0] exp_data [$];
	string exp_name [$];

	arith_core_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.load(load),
		.result_valid(result_valid),
		.result_rd(result_rd),
		.result_data(result_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [rf_addr_width-1:0] random_reg();
		return 5'(next_random());
	endfunction

	// r0 stays zero so it can serve as the neutral operand
	function automatic logic [rf_addr_width-1:0] nonzero_reg();
		return 5'(1 + next_random() % 31);
	endfunction

	function automatic core_opcode_e random_op();
		return core_opcode_e'(2'(next_random()));
	endfunction

	function automatic logic [rf_data_width-1:0] reference_result(input core_opcode_e op,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
		logic [63:0] wide_product;
		logic [33:0] wide_sum;
		logic [31:0] r;
		wide_product = {32'b0, a} * {32'b0, b};
		wide_sum = {2'b0, a} + {2'b0, b} + {2'b0, c};
		r = '0;
		case (op)
			op_madd: r = wide_product[31:0] + c;
			op_add3: r = wide_sum[31:0];
			op_bsel: begin
				for (int i = 0; i < 32; i++) begin
					r[i] = c[i] ? a[i] : b[i];
				end
			end
			op_max3: begin
				r = a;
				if (b > r) begin
					r = b;
				end
				if (c > r) begin
					r = c;
				end
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic core_instr_t make_instr(input core_opcode_e op,
			input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] rc,
			input logic [4:0] rd, input logic [3:0] mask);
		core_instr_t ins;
		ins.valid = 1'b1;
		ins.opcode = op;
		ins.rs_a = ra;
		ins.rs_b = rb;
		ins.rs_c = rc;
		ins.rd = rd;
		ins.mask = mask;
		return ins;
	endfunction

	function automatic rf_write_req_t make_load(input logic [4:0] addr,
			input logic [31:0] data, input logic [3:0] be);
		rf_write_req_t ld;
		ld.en = 1'b1;
		ld.addr = addr;
		ld.data = data;
		ld.be = be;
		return ld;
	endfunction

	function automatic void write_model(input logic [4:0] addr, input logic [31:0] data,
			input logic [3:0] be);
		for (int b = 0; b < rf_num_byte; b++) begin
			if (be[b]) begin
				model_regs[addr][b*8 +: 8] = data[b*8 +: 8];
			end
		end
	endfunction

	function automatic void pop_expected(output int cyc, output logic [4:0] rd,
			output logic [31:0] data, output string name);
		cyc = exp_cycle.pop_front();
		rd = exp_rd.pop_front();
		data = exp_data.pop_front();
		name = exp_name.pop_front();
	endfunction

	// Drives one clock cycle of stimulus and mirrors it into the reference model
	task automatic drive_cycle(input core_instr_t ins, input rf_write_req_t ld,
			input string name);
		core_stage2_t issued;
		@(posedge clk);
		instr <= ins;
		load <= ld;
		cycle_no = cycle_no + 1;
		// Port B priority means this cycle's load goes after the writeback from two cycles back
		if (wb_pipe[0].valid) begin
			write_model(wb_pipe[0].rd, wb_pipe[0].result, wb_pipe[0].mask);
		end
		if (ld.en) begin
			write_model(ld.addr, ld.data, ld.be);
		end
		wb_pipe[0] = wb_pipe[1];
		issued = '0;
		if (ins.valid) begin
			issued.valid = 1'b1;
			issued.rd = ins.rd;
			issued.mask = ins.mask;
			issued.result = reference_result(ins.opcode, model_regs[ins.rs_a],
				model_regs[ins.rs_b], model_regs[ins.rs_c]);
			exp_cycle.push_back(cycle_no + 2);
			exp_rd.push_back(ins.rd);
			exp_data.push_back(issued.result);
			exp_name.push_back(name);
		end
		wb_pipe[1] = issued;
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			drive_cycle(no_instr, rf_write_idle, "idle");
		end
	endtask

	task automatic load_and_read_all();
		logic [31:0] value;
		for (int i = 0; i < rf_num_words; i++) begin
			value = (i == 0) ? 32'h0 : next_random();
			drive_cycle(no_instr, make_load(5'(i), value, 4'hf), "load_read");
			drive_cycle(make_instr(op_add3, 5'(i), 5'd0, 5'd0, 5'(i), 4'h0),
				rf_write_idle, "load_read");
		end
	endtask

	task automatic byte_mask_tests();
		logic [rf_addr_width-1:0] r;
		logic [rf_num_byte-1:0] mask;
		for (int i = 0; i < 8; i++) begin
			r = nonzero_reg();
			mask = 4'(next_random());
			drive_cycle(no_instr, make_load(r, next_random(), mask), "partial_load");
			drive_cycle(make_instr(op_add3, r, 5'd0, 5'd0, r, 4'h0), rf_write_idle,
				"partial_load");
		end
		for (int i = 0; i < 8; i++) begin
			r = nonzero_reg();
			mask = 4'(next_random());
			drive_cycle(make_instr(random_op(), random_reg(), random_reg(), random_reg(),
				r, mask), rf_write_idle, "masked_write");
			idle_cycles(1);
			drive_cycle(make_instr(op_add3, r, 5'd0, 5'd0, r, 4'h0), rf_write_idle,
				"masked_read");
		end
	endtask

	task automatic random_op_tests(input int count, input int gap, input string name);
		for (int i = 0; i < count; i++) begin
			// Opcodes rotate so every one is covered
			drive_cycle(make_instr(core_opcode_e'(2'(i)), random_reg(), random_reg(),
				random_reg(), nonzero_reg(), 4'(next_random())), rf_write_idle, name);
			idle_cycles(gap);
		end
	endtask

	task automatic hazard_test();
		logic [31:0] step;
		step = next_random() | 32'h1;
		drive_cycle(no_instr, make_load(5'd8, step, 4'hf), "hazard_setup");
		drive_cycle(make_instr(op_add3, 5'd7, 5'd8, 5'd0, 5'd7, 4'hf), rf_write_idle,
			"hazard_producer");
		drive_cycle(make_instr(op_add3, 5'd7, 5'd0, 5'd0, 5'd10, 4'h0), rf_write_idle,
			"hazard_old_value");
		drive_cycle(make_instr(op_add3, 5'd7, 5'd0, 5'd0, 5'd10, 4'h0), rf_write_idle,
			"hazard_new_value");
	endtask

	// The load is placed in the cycle where the writeback reaches port A
	task automatic write_conflict_test(input logic [3:0] wb_mask, input logic [3:0] ld_mask);
		drive_cycle(make_instr(op_add3, random_reg(), random_reg(), random_reg(), 5'd9,
			wb_mask), rf_write_idle, "conflict_writeback");
		idle_cycles(1);
		drive_cycle(no_instr, make_load(5'd9, next_random(), ld_mask), "conflict_load");
		drive_cycle(make_instr(op_add3, 5'd9, 5'd0, 5'd0, 5'd9, 4'h0), rf_write_idle,
			"conflict_read");
	endtask

	always @(negedge clk) begin : compare_results
		int want_cycle;
		logic [4:0] want_rd;
		logic [31:0] want_data;
		string name;
		if (rst_n && result_valid) begin
			if (exp_cycle.size() == 0) begin
				error_count++;
				$display("Result for r%0d in cycle %0d with no instruction in flight",
					result_rd, cycle_no);
			end else begin
				pop_expected(want_cycle, want_rd, want_data, name);
				check_count++;
				if (want_cycle != cycle_no) begin
					error_count++;
					$display("%s: result came in cycle %0d but was due in cycle %0d",
						name, cycle_no, want_cycle);
				end
				if (result_rd != want_rd) begin
					error_count++;
					$display("[ERROR] %s: result_rd expected %0d actual %0d",
						name, want_rd, result_rd);
				end
				if (result_data != want_data) begin
					error_count++;
					$display("[ERROR] %s: result_data expected %08h actual %08h",
						name, want_data, result_data);
				end
			end
		end else if (rst_n && exp_cycle.size() != 0 && exp_cycle[0] <= cycle_no) begin
			pop_expected(want_cycle, want_rd, want_data, name);
			error_count++;
			$display("%s: no result appeared in cycle %0d", name, want_cycle);
		end
	end

	initial begin
		rng_state = 32'hf898;
		cycle_no = 0;
		check_count = 0;
		error_count = 0;
		wb_pipe[0] = '0;
		wb_pipe[1] = '0;
		for (int i = 0; i < rf_num_words; i++) begin
			model_regs[i] = '0;
		end
		rst_n = 1'b0;
		instr = no_instr;
		load = rf_write_idle;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		load_and_read_all();
		byte_mask_tests();
		random_op_tests(40, 2, "random_op");
		random_op_tests(24, 0, "back_to_back");
		hazard_test();
		write_conflict_test(4'b0110, 4'b0011);
		write_conflict_test(4'b1111, 4'b0101);
		idle_cycles(6);
		// The last compare runs on the falling edge before this
		@(posedge clk);
		if (exp_cycle.size() != 0) begin
			error_count++;
			$display("%0d expected results never arrived", exp_cycle.size());
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#((reset_cycles + test_cycles + margin_cycles) * clk_period);
		$display("Watchdog expired, the tests did not finish within %0d cycles",
			reset_cycles + test_cycles + margin_cycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== filelist.f ====
rf_pkg.sv
core_pkg.sv
operand_decoder.sv
register_file_3r_2w_be.sv
ternary_alu.sv
writeback_stage.sv
arith_core_top.sv
tb_arith_core.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_arith_core \
		-f filelist.f -Mdir obj_dir -o tb_arith_core

run: build
	./obj_dir/tb_arith_core | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module tb_arith_core \
		-f filelist.f

clean:
	rm -rf obj_dir $(LOG)
